// File: rx_bond_golden.txt
# in  <test> <cycles> <valid mask> <headers, 2 bits per lane> <en_chan_sync>
# cb  <test> <skews, 4 bits per lane> <cycles> <bad header block> <bad header lane>
# exp <test> <lock|rst|nout|herr|berr|align> <value>, all numbers in hex
in lock 8 f 55 0
in lock 1 f 15 0
in lock 7 f 55 0
exp lock lock 7
in lock 8 f 55 0
exp lock lock 7
in lock 1 f 55 0
exp lock lock f
in link 18 f 55 0
exp link rst 10
cb skew_err 2510 c 0 0
exp skew_err berr 1
exp skew_err nout 0
exp skew_err align 0
cb deskew 1420 14 6 2
exp deskew nout d
exp deskew herr 1
exp deskew berr 0
exp deskew align 1

// File: sources.f
+incdir+.
rx_bond_pkg.sv
rx_block_sync_gate.sv
rx_cdr_reset_fsm.sv
rx_deskew_lane.sv
rx_bond_aligner.sv
rx_bond_top.sv
tb_rx_bond.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the testbench; the exit status is the simulation result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_rx_bond -f sources.f &&
./obj_dir/Vtb_rx_bond || { echo "simulation failed"; exit 1; }

// File: tb_rx_bond.sv
`timescale 1ns/10ps
`include "rx_bond_settings.svh"

module tb_rx_bond;

    logic                                       rxusrclk_out = 1'b0;
    logic                                       reset_i;
    rx_bond_pkg::block_data_t  [`NUM_LANES-1:0] rx_data_i;
    rx_bond_pkg::sync_header_t [`NUM_LANES-1:0] rx_header_i;
    logic                      [`NUM_LANES-1:0] rx_valid_i;
    logic                                       en_chan_sync_i;
    rx_bond_pkg::block_data_t  [`NUM_LANES-1:0] rx_data_o;
    rx_bond_pkg::sync_header_t [`NUM_LANES-1:0] rx_header_o;
    logic                      [`NUM_LANES-1:0] rx_valid_o;
    logic                      [`NUM_LANES-1:0] rx_header_err_o;
    logic                      [`NUM_LANES-1:0] lane_lock_o;
    logic                                       link_reset_o;
    logic                                       chan_aligned_o;
    logic                                       bond_err_o;

    int   cycle_cnt = 0;
    int   cycle_limit = 1000;
    int   link_cycles = 0;
    logic link_done = 1'b0;
    logic early_valid = 1'b0;
    int   n_out;
    int   n_herr;
    int   n_berr;
    logic aligned_seen;

    rx_bond_top rx_bond_top_i (
        .rxusrclk_out    (rxusrclk_out),
        .reset_i         (reset_i),
        .rx_data_i       (rx_data_i),
        .rx_header_i     (rx_header_i),
        .rx_valid_i      (rx_valid_i),
        .en_chan_sync_i  (en_chan_sync_i),
        .rx_data_o       (rx_data_o),
        .rx_header_o     (rx_header_o),
        .rx_valid_o      (rx_valid_o),
        .rx_header_err_o (rx_header_err_o),
        .lane_lock_o     (lane_lock_o),
        .link_reset_o    (link_reset_o),
        .chan_aligned_o  (chan_aligned_o),
        .bond_err_o      (bond_err_o)
    );

    always #10 rxusrclk_out = ~rxusrclk_out;

    task automatic stop_failed();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    always @(posedge rxusrclk_out) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: the test did not finish within %0d cycles", cycle_limit);
            stop_failed();
        end
    end

    // Measures the link reset and watches for output data that comes too early
    always @(negedge rxusrclk_out) begin
        if (!reset_i) begin
            if (link_reset_o) link_cycles++;
            if (link_cycles > 0 && !link_reset_o) link_done = 1'b1;
            if (|rx_valid_o && !link_done) early_valid = 1'b1;
        end
    end

    task automatic check_data(string name, rx_bond_pkg::block_data_t exp_v,
                              rx_bond_pkg::block_data_t act_v);
        if (act_v !== exp_v) begin
            $display("mismatch %s: expected %h, actual %h", name, exp_v, act_v);
            stop_failed();
        end
    endtask

    task automatic check_header(string name, rx_bond_pkg::sync_header_t exp_v,
                                rx_bond_pkg::sync_header_t act_v);
        if (act_v !== exp_v) begin
            $display("mismatch %s: expected %b, actual %b", name, exp_v, act_v);
            stop_failed();
        end
    endtask

    task automatic check_flag(string name, logic exp_v, logic act_v);
        if (act_v !== exp_v) begin
            $display("mismatch %s: expected %b, actual %b", name, exp_v, act_v);
            stop_failed();
        end
    endtask

    task automatic check_count(string name, int exp_v, int act_v);
        if (act_v != exp_v) begin
            $display("mismatch %s: expected %0d, actual %0d", name, exp_v, act_v);
            stop_failed();
        end
    endtask

    // Block k of a lane counts from its bonding block, which is block 0
    function automatic rx_bond_pkg::block_data_t block_data(int lane, int k);
        if (k < 0) return '0;
        if (k == 0) return {rx_bond_pkg::CB_BLOCK_TYPE, 48'h0, 8'(lane)};
        return {8'hd0, 40'h0, 8'(lane), 8'(k)};
    endfunction

    function automatic rx_bond_pkg::sync_header_t block_header(int lane, int k,
                                                               int err_k, int err_lane);
        if (k == 0) return 2'b10;
        if (err_k != 0 && k == err_k && lane == err_lane) return 2'b11;
        return 2'b01;
    endfunction

    task automatic run_in(int cycles, logic [`NUM_LANES-1:0] valid,
                          logic [2*`NUM_LANES-1:0] hdr, logic en);
        repeat (cycles) begin
            for (int l = 0; l < `NUM_LANES; l++) begin
                rx_data_i[l]   = '0;
                rx_header_i[l] = hdr[2*l +: 2];
            end
            rx_valid_i     = valid;
            en_chan_sync_i = en;
            @(negedge rxusrclk_out);
        end
    endtask

    // Streams every lane from its own bonding block on and checks what comes out
    task automatic run_bond(string name, logic [4*`NUM_LANES-1:0] skews, int cycles,
                            int err_k, int err_lane);
        int skew [`NUM_LANES];
        int out_k;
        rx_bond_pkg::sync_header_t hdr;
        out_k        = 0;
        n_out        = 0;
        n_herr       = 0;
        n_berr       = 0;
        aligned_seen = 1'b0;
        for (int l = 0; l < `NUM_LANES; l++) skew[l] = int'(skews[4*l +: 4]);
        run_in($urandom_range(3, 1), '0, {`NUM_LANES{2'b01}}, 1'b0);
        for (int t = 0; t < cycles; t++) begin
            for (int l = 0; l < `NUM_LANES; l++) begin
                rx_data_i[l]   = block_data(l, t - skew[l]);
                rx_header_i[l] = block_header(l, t - skew[l], err_k, err_lane);
            end
            rx_valid_i     = '1;
            en_chan_sync_i = 1'b1;
            @(negedge rxusrclk_out);
            // A bad header drops the lane lock one cycle after it is sent
            if (err_k != 0 && t == err_k + skew[err_lane] - 1) begin
                check_flag($sformatf("%s lane %0d lock before bad header", name, err_lane),
                           1'b1, lane_lock_o[err_lane]);
            end
            if (err_k != 0 && t == err_k + skew[err_lane]) begin
                check_flag($sformatf("%s lane %0d lock after bad header", name, err_lane),
                           1'b0, lane_lock_o[err_lane]);
            end
            if (|rx_valid_o) begin
                for (int l = 0; l < `NUM_LANES; l++) begin
                    hdr = block_header(l, out_k, err_k, err_lane);
                    check_flag($sformatf("%s lane %0d valid", name, l), 1'b1, rx_valid_o[l]);
                    check_data($sformatf("%s lane %0d data", name, l),
                               block_data(l, out_k), rx_data_o[l]);
                    check_header($sformatf("%s lane %0d header", name, l), hdr, rx_header_o[l]);
                    check_flag($sformatf("%s lane %0d header_err", name, l),
                               hdr == 2'b00 || hdr == 2'b11, rx_header_err_o[l]);
                end
                out_k++;
                n_out++;
            end
            n_herr += $countones(rx_header_err_o);
            if (bond_err_o) n_berr++;
            if (chan_aligned_o) aligned_seen = 1'b1;
        end
    endtask

    initial begin
        int          fd;
        int          code;
        string       line;
        string       kw;
        string       name;
        string       kind;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        string       lines[$];
        void'($urandom(34));
        reset_i        = 1'b1;
        rx_data_i      = '0;
        rx_header_i    = '0;
        rx_valid_i     = '0;
        en_chan_sync_i = 1'b0;
        fd = $fopen("rx_bond_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open rx_bond_golden.txt");
            stop_failed();
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0) lines.push_back(line);
        end
        $fclose(fd);
        cycle_limit = lines.size() + `SYNC_LOCK_COUNT + `CDR_HOLD_CYCLES + 64;
        repeat (2) @(posedge rxusrclk_out);
        @(negedge rxusrclk_out);
        reset_i = 1'b0;
        foreach (lines[i]) begin
            line = lines[i];
            code = $sscanf(line, "%s", kw);
            if (code < 1 || kw.substr(0, 0) == "#") continue;
            if (kw == "in") begin
                code = $sscanf(line, "%s %s %h %h %h %h", kw, name, a, b, c, d);
                run_in(int'(a), b[`NUM_LANES-1:0], c[2*`NUM_LANES-1:0], d[0]);
            end else if (kw == "cb") begin
                code = $sscanf(line, "%s %s %h %h %h %h", kw, name, a, b, c, d);
                run_bond(name, a[4*`NUM_LANES-1:0], int'(b), int'(c), int'(d));
            end else if (kw == "exp") begin
                code = $sscanf(line, "%s %s %s %h", kw, name, kind, a);
                case (kind)
                    "lock": begin
                        for (int l = 0; l < `NUM_LANES; l++) begin
                            check_flag($sformatf("%s lane %0d lock", name, l),
                                       a[l], lane_lock_o[l]);
                        end
                    end
                    "rst": begin
                        check_count({name, " link reset cycles"}, int'(a), link_cycles);
                        check_flag({name, " valid before link reset end"}, 1'b0, early_valid);
                    end
                    "nout":  check_count({name, " output blocks"}, int'(a), n_out);
                    "herr":  check_count({name, " header errors"}, int'(a), n_herr);
                    "berr":  check_count({name, " bond errors"}, int'(a), n_berr);
                    "align": check_flag({name, " chan_aligned"}, a[0], aligned_seen);
                    default: begin
                        $display("unknown check %s in the golden file", kind);
                        stop_failed();
                    end
                endcase
            end else begin
                $display("unknown line in the golden file: %s", line);
                stop_failed();
            end
        end
        if (!early_valid) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("output data appeared before the link reset ended");
            stop_failed();
        end
    end

endmodule

// File: rx_bond_top.sv
`timescale 1ns/10ps
`include "rx_bond_settings.svh"

module rx_bond_top (
    input  logic                                       rxusrclk_out,
    input  logic                                       reset_i,
    input  rx_bond_pkg::block_data_t  [`NUM_LANES-1:0] rx_data_i,
    input  rx_bond_pkg::sync_header_t [`NUM_LANES-1:0] rx_header_i,
    input  logic                      [`NUM_LANES-1:0] rx_valid_i,
    input  logic                                       en_chan_sync_i,
    output rx_bond_pkg::block_data_t  [`NUM_LANES-1:0] rx_data_o,
    output rx_bond_pkg::sync_header_t [`NUM_LANES-1:0] rx_header_o,
    output logic                      [`NUM_LANES-1:0] rx_valid_o,
    output logic                      [`NUM_LANES-1:0] rx_header_err_o,
    output logic                      [`NUM_LANES-1:0] lane_lock_o,
    output logic                                       link_reset_o,
    output logic                                       chan_aligned_o,
    output logic                                       bond_err_o
);

    rx_bond_pkg::block_data_t  [`NUM_LANES-1:0] gated_data;
    rx_bond_pkg::sync_header_t [`NUM_LANES-1:0] gated_header;
    logic                      [`NUM_LANES-1:0] gated_valid;
    logic                      [`NUM_LANES-1:0] cb_found;
    logic                      [`NUM_LANES-1:0] overflow;
    logic                                       all_lock;
    logic                                       link_reset;
    logic                                       propagation_ok;
    logic                                       rd_en;
    logic                                       bond_restart;
    logic                                       lane_clear;
    logic                                       aligner_reset;

    assign lane_clear    = link_reset | bond_restart;
    assign aligner_reset = reset_i | link_reset;

    rx_block_sync_gate rx_block_sync_gate_i (
        .rxusrclk_out     (rxusrclk_out),
        .reset_i          (reset_i),
        .rx_data_i        (rx_data_i),
        .rx_header_i      (rx_header_i),
        .rx_valid_i       (rx_valid_i),
        .propagation_ok_i (propagation_ok),
        .gated_data_o     (gated_data),
        .gated_header_o   (gated_header),
        .gated_valid_o    (gated_valid),
        .lane_lock_o      (lane_lock_o),
        .all_lock_o       (all_lock)
    );

    rx_cdr_reset_fsm rx_cdr_reset_fsm_i (
        .rxusrclk_out     (rxusrclk_out),
        .reset_i          (reset_i),
        .all_lock_i       (all_lock),
        .link_reset_o     (link_reset),
        .propagation_ok_o (propagation_ok)
    );

    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
        rx_deskew_lane rx_deskew_lane_i (
            .rxusrclk_out   (rxusrclk_out),
            .reset_i        (reset_i),
            .clear_i        (lane_clear),
            .en_chan_sync_i (en_chan_sync_i),
            .in_data_i      (gated_data[i]),
            .in_header_i    (gated_header[i]),
            .in_valid_i     (gated_valid[i]),
            .rd_en_i        (rd_en),
            .cb_found_o     (cb_found[i]),
            .overflow_o     (overflow[i]),
            .out_data_o     (rx_data_o[i]),
            .out_header_o   (rx_header_o[i]),
            .out_valid_o    (rx_valid_o[i]),
            .header_err_o   (rx_header_err_o[i])
        );
    end

    rx_bond_aligner rx_bond_aligner_i (
        .rxusrclk_out   (rxusrclk_out),
        .reset_i        (aligner_reset),
        .cb_found_i     (cb_found),
        .overflow_i     (overflow),
        .rd_en_o        (rd_en),
        .bond_restart_o (bond_restart),
        .chan_aligned_o (chan_aligned_o),
        .bond_err_o     (bond_err_o)
    );

    assign link_reset_o = link_reset;

endmodule

// File: rx_bond_aligner.sv
`timescale 1ns/10ps
`include "rx_bond_settings.svh"

module rx_bond_aligner (
    input  logic                  rxusrclk_out,
    input  logic                  reset_i,
    input  logic [`NUM_LANES-1:0] cb_found_i,
    input  logic [`NUM_LANES-1:0] overflow_i,
    output logic                  rd_en_o,
    output logic                  bond_restart_o,
    output logic                  chan_aligned_o,
    output logic                  bond_err_o
);

    localparam rx_bond_pkg::skew_cnt_t SKEW_MAX = rx_bond_pkg::skew_cnt_t'(`CB_MAX_SKEW);

    rx_bond_pkg::skew_cnt_t skew_cnt_r;
    logic                   rd_en_r;
    logic                   aligned_r;
    logic                   restart_r;
    logic                   bond_err_r;
    logic                   any_found;
    logic                   all_found;
    logic                   skew_err;
    logic                   ovf_err;
    logic                   bond_fail;

    assign any_found = |cb_found_i;
    assign all_found = &cb_found_i;

    // The last lane is already later than the skew limit allows
    assign skew_err = any_found && !all_found && (skew_cnt_r == SKEW_MAX);
    assign ovf_err  = |overflow_i;

    // Lane flags are stale while the restart pulse is clearing them
    assign bond_fail = !restart_r && (skew_err || ovf_err);

    always_ff @(posedge rxusrclk_out) begin
        if (reset_i) begin
            skew_cnt_r <= '0;
            rd_en_r    <= 1'b0;
            aligned_r  <= 1'b0;
            restart_r  <= 1'b0;
            bond_err_r <= 1'b0;
        end else begin
            restart_r  <= bond_fail;
            bond_err_r <= bond_fail;
            if (bond_fail || restart_r) begin
                skew_cnt_r <= '0;
                rd_en_r    <= 1'b0;
                aligned_r  <= 1'b0;
            end else begin
                if (any_found && !all_found) begin
                    skew_cnt_r <= skew_cnt_r + 1'b1; // Cycles since the first bonding block
                end
                if (all_found) begin
                    rd_en_r <= 1'b1;
                end
                aligned_r <= rd_en_r; // Follows the first read out of the lanes
            end
        end
    end

    assign rd_en_o        = rd_en_r;
    assign bond_restart_o = restart_r;
    assign chan_aligned_o = aligned_r;
    assign bond_err_o     = bond_err_r;

endmodule

// File: rx_deskew_lane.sv
`timescale 1ns/10ps
`include "rx_bond_settings.svh"

module rx_deskew_lane (
    input  logic                      rxusrclk_out,
    input  logic                      reset_i,
    input  logic                      clear_i,
    input  logic                      en_chan_sync_i,
    input  rx_bond_pkg::block_data_t  in_data_i,
    input  rx_bond_pkg::sync_header_t in_header_i,
    input  logic                      in_valid_i,
    input  logic                      rd_en_i,
    output logic                      cb_found_o,
    output logic                      overflow_o,
    output rx_bond_pkg::block_data_t  out_data_o,
    output rx_bond_pkg::sync_header_t out_header_o,
    output logic                      out_valid_o,
    output logic                      header_err_o
);

    localparam int ADDR_W = $clog2(`FIFO_DEPTH);

    rx_bond_pkg::block_data_t  mem_data [`FIFO_DEPTH];
    rx_bond_pkg::sync_header_t mem_hdr  [`FIFO_DEPTH];

    rx_bond_pkg::fifo_ptr_t    wr_ptr_r;
    rx_bond_pkg::fifo_ptr_t    rd_ptr_r;
    rx_bond_pkg::block_data_t  out_data_r;
    rx_bond_pkg::sync_header_t out_header_r;
    logic                      cb_found_r;
    logic                      overflow_r;
    logic                      out_valid_r;
    logic                      header_err_r;
    logic                      cb_hit;
    logic                      wr_req;
    logic                      wr_en;
    logic                      rd_en;
    logic                      full;
    logic                      empty;

    // A bonding block is a control block carrying the bonding type in its top byte
    assign cb_hit = in_valid_i && en_chan_sync_i && !cb_found_r &&
                    (in_header_i == rx_bond_pkg::HDR_CTRL) &&
                    (in_data_i[63:56] == rx_bond_pkg::CB_BLOCK_TYPE);

    assign wr_req = in_valid_i && (cb_found_r || cb_hit);
    assign wr_en  = wr_req && !full;
    assign rd_en  = rd_en_i && !empty;

    assign empty = (wr_ptr_r == rd_ptr_r);
    assign full  = (wr_ptr_r[ADDR_W] != rd_ptr_r[ADDR_W]) &&
                   (wr_ptr_r[ADDR_W-1:0] == rd_ptr_r[ADDR_W-1:0]);

    always_ff @(posedge rxusrclk_out) begin
        if (wr_en) begin
            mem_data[wr_ptr_r[ADDR_W-1:0]] <= in_data_i;
            mem_hdr[wr_ptr_r[ADDR_W-1:0]]  <= in_header_i;
        end
        if (rd_en) begin
            out_data_r   <= mem_data[rd_ptr_r[ADDR_W-1:0]];
            out_header_r <= mem_hdr[rd_ptr_r[ADDR_W-1:0]];
        end
    end

    always_ff @(posedge rxusrclk_out) begin
        if (reset_i || clear_i) begin
            wr_ptr_r     <= '0;
            rd_ptr_r     <= '0;
            cb_found_r   <= 1'b0;
            overflow_r   <= 1'b0;
            out_valid_r  <= 1'b0;
            header_err_r <= 1'b0;
        end else begin
            if (cb_hit) begin
                cb_found_r <= 1'b1;
            end
            if (wr_en) begin
                wr_ptr_r <= wr_ptr_r + 1'b1;
            end
            if (rd_en) begin
                rd_ptr_r <= rd_ptr_r + 1'b1;
            end
            overflow_r   <= wr_req && full; // Block is dropped
            out_valid_r  <= rd_en;
            header_err_r <= rd_en && !rx_bond_pkg::hdr_valid(mem_hdr[rd_ptr_r[ADDR_W-1:0]]);
        end
    end

    assign cb_found_o   = cb_found_r;
    assign overflow_o   = overflow_r;
    assign out_data_o   = out_data_r;
    assign out_header_o = out_header_r;
    assign out_valid_o  = out_valid_r;
    assign header_err_o = header_err_r;

    // The common read enable must never run ahead of this lane's data
    a_no_read_empty: assert property (@(posedge rxusrclk_out) disable iff (reset_i || clear_i)
        rd_en_i |-> !empty);

endmodule

// File: rx_cdr_reset_fsm.sv
`timescale 1ns/10ps
`include "rx_bond_settings.svh"

module rx_cdr_reset_fsm (
    input  logic rxusrclk_out,
    input  logic reset_i,
    input  logic all_lock_i,
    output logic link_reset_o,
    output logic propagation_ok_o
);

    localparam rx_bond_pkg::hold_cnt_t HOLD_LAST =
        rx_bond_pkg::hold_cnt_t'(`CDR_HOLD_CYCLES - 1);

    rx_bond_pkg::cdr_state_t state_r;
    rx_bond_pkg::hold_cnt_t  hold_cnt_r;
    logic                    link_reset_r;
    logic                    prop_ok_r;

    always_ff @(posedge rxusrclk_out) begin
        if (reset_i) begin
            state_r      <= rx_bond_pkg::IDLE;
            hold_cnt_r   <= '0;
            link_reset_r <= 1'b0;
            prop_ok_r    <= 1'b0;
        end else begin
            case (state_r)
                rx_bond_pkg::IDLE: begin
                    hold_cnt_r <= '0;
                    prop_ok_r  <= 1'b0;
                    if (all_lock_i) begin
                        state_r      <= rx_bond_pkg::ASSERT_LINK_RESET;
                        link_reset_r <= 1'b1;
                    end
                end
                rx_bond_pkg::ASSERT_LINK_RESET: begin
                    if (hold_cnt_r == HOLD_LAST) begin
                        state_r      <= rx_bond_pkg::DONE;
                        link_reset_r <= 1'b0;
                        prop_ok_r    <= 1'b1;
                    end else begin
                        hold_cnt_r <= hold_cnt_r + 1'b1;
                    end
                end
                rx_bond_pkg::DONE: begin
                    hold_cnt_r   <= '0;
                    link_reset_r <= 1'b0;
                    prop_ok_r    <= 1'b1; // Stays here until the next reset
                end
                default: begin
                    state_r <= rx_bond_pkg::IDLE;
                end
            endcase
        end
    end

    assign link_reset_o     = link_reset_r;
    assign propagation_ok_o = prop_ok_r;

    a_reset_excludes_prop: assert property (@(posedge rxusrclk_out) disable iff (reset_i)
        !(link_reset_o && propagation_ok_o));

    // The link reset is one pulse of the full hold length
    a_reset_length: assert property (@(posedge rxusrclk_out) disable iff (reset_i)
        $rose(link_reset_o) |-> link_reset_o [*`CDR_HOLD_CYCLES] ##1 !link_reset_o);

endmodule

// File: rx_block_sync_gate.sv
`timescale 1ns/10ps
`include "rx_bond_settings.svh"

module rx_block_sync_gate (
    input  logic                                          rxusrclk_out,
    input  logic                                          reset_i,
    input  rx_bond_pkg::block_data_t  [`NUM_LANES-1:0]    rx_data_i,
    input  rx_bond_pkg::sync_header_t [`NUM_LANES-1:0]    rx_header_i,
    input  logic                      [`NUM_LANES-1:0]    rx_valid_i,
    input  logic                                          propagation_ok_i,
    output rx_bond_pkg::block_data_t  [`NUM_LANES-1:0]    gated_data_o,
    output rx_bond_pkg::sync_header_t [`NUM_LANES-1:0]    gated_header_o,
    output logic                      [`NUM_LANES-1:0]    gated_valid_o,
    output logic                      [`NUM_LANES-1:0]    lane_lock_o,
    output logic                                          all_lock_o
);

    localparam rx_bond_pkg::lock_cnt_t LOCK_MAX = rx_bond_pkg::lock_cnt_t'(`SYNC_LOCK_COUNT);

    rx_bond_pkg::lock_cnt_t                       lock_cnt_r [`NUM_LANES];
    logic                      [`NUM_LANES-1:0]   lane_lock_r;
    rx_bond_pkg::block_data_t  [`NUM_LANES-1:0]   data_r;
    rx_bond_pkg::sync_header_t [`NUM_LANES-1:0]   header_r;
    logic                      [`NUM_LANES-1:0]   valid_r;

    // One saturating lock counter per lane
    always_ff @(posedge rxusrclk_out) begin
        if (reset_i) begin
            for (int l = 0; l < `NUM_LANES; l++) begin
                lock_cnt_r[l] <= '0;
            end
            lane_lock_r <= '0;
        end else begin
            for (int l = 0; l < `NUM_LANES; l++) begin
                if (rx_valid_i[l]) begin
                    if (rx_bond_pkg::hdr_valid(rx_header_i[l])) begin
                        if (lock_cnt_r[l] != LOCK_MAX) begin
                            lock_cnt_r[l] <= lock_cnt_r[l] + 1'b1;
                        end
                        if (lock_cnt_r[l] == LOCK_MAX - 1'b1) begin
                            lane_lock_r[l] <= 1'b1; // This header completes the run
                        end
                    end else begin
                        lock_cnt_r[l]  <= '0;
                        lane_lock_r[l] <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge rxusrclk_out) begin
        data_r   <= rx_data_i;
        header_r <= rx_header_i;
    end

    // Nothing reaches the lanes until the link reset has finished
    always_ff @(posedge rxusrclk_out) begin
        if (reset_i) begin
            valid_r <= '0;
        end else begin
            valid_r <= rx_valid_i & {`NUM_LANES{propagation_ok_i}};
        end
    end

    assign gated_data_o   = data_r;
    assign gated_header_o = header_r;
    assign gated_valid_o  = valid_r;
    assign lane_lock_o    = lane_lock_r;
    assign all_lock_o     = &lane_lock_r;

endmodule

// File: rx_bond_pkg.sv
`include "rx_bond_settings.svh"

package rx_bond_pkg;

    typedef logic [63:0] block_data_t;
    typedef logic [1:0]  sync_header_t;
    typedef logic [7:0]  block_type_t;

    typedef logic [$clog2(`CB_MAX_SKEW + 1)-1:0]     skew_cnt_t;
    typedef logic [$clog2(`FIFO_DEPTH):0]            fifo_ptr_t; // Extra bit tells full from empty
    typedef logic [$clog2(`CDR_HOLD_CYCLES + 1)-1:0] hold_cnt_t;
    typedef logic [$clog2(`SYNC_LOCK_COUNT + 1)-1:0] lock_cnt_t;

    localparam sync_header_t HDR_DATA = 2'b01;
    localparam sync_header_t HDR_CTRL = 2'b10;

    // Control block type that marks a channel bonding block
    localparam block_type_t CB_BLOCK_TYPE = 8'h78;

    typedef enum logic [1:0] {
        IDLE,
        ASSERT_LINK_RESET,
        DONE
    } cdr_state_t;

    function automatic logic hdr_valid(sync_header_t hdr);
        return (hdr == HDR_DATA) || (hdr == HDR_CTRL);
    endfunction

endpackage

// File: rx_bond_settings.svh
`ifndef RX_BOND_SETTINGS_SVH
`define RX_BOND_SETTINGS_SVH

// Number of bonded lanes
`define NUM_LANES 4

// Deskew FIFO entries per lane (a power of two)
`define FIFO_DEPTH 8

// Most cycles allowed between the first and the last lane finding its bonding block
`define CB_MAX_SKEW 4

// Consecutive valid sync headers before a lane counts as locked
`define SYNC_LOCK_COUNT 16

// Length of the one-shot link reset in cycles
`define CDR_HOLD_CYCLES 16

`endif
